// ==== dv/qla_vectors.txt ====
// columns: op addr data expect slverr, all hex, one operation per line
// op 1 write, 2 read, 3 set feedback (addr = axis index), 4 wait cycles, 5 random hub fill,
// op 6 hub readback, 7 check cur_cmd (addr = axis index), 8 check amp_en, 0 end
5 1000 00000000 00000000 0
6 1000 00000000 00000000 0
// axis 1 command, axis 2 feedback
1 0011 00009000 00000000 0
7 0000 00000000 00009000 0
2 0011 00000000 00009000 0
3 0001 000080f0 00000000 0
2 0020 00000000 000080f0 0
// board status, board id 0xa
1 0000 0008000f 00000000 0
8 0000 00000000 0000000f 0
2 0000 00000000 0a08000f 0
// axis 3 trips after 40 cycles of feedback far above 2x command
1 0031 00008100 00000000 0
3 0002 00009000 00000000 0
4 0000 00000028 00000000 0
2 0000 00000000 0a08040f 0
8 0000 00000000 0000000b 0
7 0000 00000000 00009000 0
3 0002 00008000 00000000 0
1 0031 00008000 00000000 0
8 0000 00000000 0000000f 0
// unmapped space, channel and offset
2 2000 00000000 00000000 1
2 0050 00000000 00000000 1
2 0012 00000000 00000000 1
1 2003 deadbeef 00000000 1
1 0001 00000000 00000000 1
1 0050 00000000 00000000 1
1 0010 00001234 00000000 0
2 0010 00000000 00008000 0
6 1000 00000000 00000000 0
2 0000 00000000 0a08000f 0
2 0011 00000000 00009000 0
0 0000 00000000 00000000 0

// ==== dv/tb_qla.sv ====
module tb_qla;
    timeunit 1ns;
    timeprecision 1ps;
    import qla_pkg::*;

    localparam int NUM_AXES  = 4;
    localparam int MAX_WORDS = 5 * 64;    // 5 words per vector line
    localparam int TIMEOUT   = 20;        // cycles to wait for pready

    logic                      sysclk, rst_n;
    logic                      psel, penable, pwrite;
    logic [15:0]               paddr;
    logic [31:0]               pwdata, prdata;
    logic                      pready, pslverr;
    logic [3:0]                board_id;
    axis_val_t [NUM_AXES-1:0]  cur_fb, cur_cmd;
    logic [NUM_AXES-1:0]       amp_en;
    logic                      pwr_enable;

    bit [31:0]   vec [MAX_WORDS];      // op, addr, data, expect, slverr
    logic [31:0] hub_model [16];       // what the hub should hold
    logic        pwr_model    = 1'b0;  // bit 19 of the last board write
    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;     // timeouts and bad vectors
    bit          timed_out    = 0;

    qla_top #(.NUM_AXES(NUM_AXES)) qla_top_inst (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;  // 40 ns period
    end

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_rdata(input string what, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_axis(input string what, input axis_val_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flags(input string what, input logic [NUM_AXES-1:0] got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // apb master, setup then access until pready
    // ----------------------------------------------------------------------
    task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
        int waited;
        @(negedge sysclk);
        psel    = 1'b1;                // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge sysclk);
        penable = 1'b1;
        waited  = 0;
        do begin
            @(negedge sysclk);
            waited++;
        end while (!pready && waited < TIMEOUT);
        if (!pready) begin
            $display("timeout: no pready for access to %h at %0t ns", addr, $time);
            fail_cnt++;
            timed_out = 1'b1;
        end
        rd      = prdata;              // stable since the last rising edge
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic hub_fill(input logic [15:0] base);
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < 16; i++) begin
            hub_model[i] = $urandom;
            apb_access(1'b1, {base[15:4], 4'(i)}, hub_model[i], rd, err);
            check_flags("hub write slverr", NUM_AXES'(err), '0);
        end
    endtask

    task automatic hub_check(input logic [15:0] base);
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < 16; i++) begin
            apb_access(1'b0, {base[15:4], 4'(i)}, '0, rd, err);
            check_rdata($sformatf("hub word %0d", i), rd, hub_model[i]);
            check_flags("hub read slverr", NUM_AXES'(err), '0);
        end
    endtask

    // ----------------------------------------------------------------------
    // vector replay
    // ----------------------------------------------------------------------
    initial begin
        int          idx;
        int          n_ops;
        bit [31:0]   op, addr, data, expv, errv;
        logic [31:0] rd;
        logic        err;
        void'($urandom(51356));
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        board_id = 4'ha;
        cur_fb   = {NUM_AXES{AXIS_ZERO}};    // zero current on every axis
        $readmemh("dv/qla_vectors.txt", vec);
        repeat (16) @(posedge sysclk);       // reset cycles
        @(negedge sysclk);
        rst_n = 1'b1;
        idx   = 0;
        n_ops = 0;
        while (idx < MAX_WORDS && vec[idx] != 0 && !timed_out) begin
            op   = vec[idx];
            addr = vec[idx+1];
            data = vec[idx+2];
            expv = vec[idx+3];
            errv = vec[idx+4];
            case (op)
                1: begin                       // write
                    apb_access(1'b1, addr[15:0], data, rd, err);
                    check_flags($sformatf("slverr on write %h", addr[15:0]),
                                NUM_AXES'(err), NUM_AXES'(errv[0]));
                    if (addr[15:0] == {ADDR_MAIN, 8'h00, OFF_BOARD_STATUS}) begin
                        pwr_model = data[19];  // board control word
                    end
                end
                2: begin                       // read
                    apb_access(1'b0, addr[15:0], '0, rd, err);
                    check_rdata($sformatf("addr %h", addr[15:0]), rd, expv);
                    check_flags($sformatf("slverr on read %h", addr[15:0]),
                                NUM_AXES'(err), NUM_AXES'(errv[0]));
                end
                3: begin
                    @(negedge sysclk);
                    cur_fb[int'(addr)] = data[15:0];
                end
                4: repeat (data) @(negedge sysclk);
                5: hub_fill(addr[15:0]);
                6: hub_check(addr[15:0]);
                7: begin
                    @(negedge sysclk);
                    check_axis($sformatf("cur_cmd[%0d]", addr), cur_cmd[int'(addr)],
                               expv[15:0]);
                end
                8: begin
                    @(negedge sysclk);
                    check_flags("amp_en", amp_en, expv[NUM_AXES-1:0]);
                    check_flags("pwr_enable", NUM_AXES'(pwr_enable), NUM_AXES'(pwr_model));
                end
                default: begin
                    $display("bad op code %0d in vector line %0d", op, idx / 5);
                    fail_cnt++;
                end
            endcase
            idx += 5;
            n_ops++;
        end
        if (n_ops == 0) begin
            $display("no vectors were read from dv/qla_vectors.txt");
            fail_cnt++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the qla testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -sv --timescale 1ns/1ps -f src.f \
    --top-module tb_qla -Mdir obj_dir -o sim_qla
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_qla > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
exit 1

// ==== src.f ====
src/qla_pkg.sv
src/qla_apb_bridge.sv
src/qla_addr_decode.sv
src/qla_hub_mem.sv
src/qla_axis_ctrl.sv
src/qla_board_regs.sv
src/qla_top.sv
dv/tb_qla.sv

// ==== src/qla_addr_decode.sv ====
module qla_addr_decode #(
    parameter int NUM_AXES = 4
) (
    input  qla_pkg::reg_req_t         req,
    output qla_pkg::reg_rsp_t         rsp,
    output logic [NUM_AXES-1:0]       axis_wen,
    input  logic [NUM_AXES-1:0][31:0] axis_rdata,
    output logic                      board_wen,
    input  logic [31:0]               board_rdata,
    output logic                      hub_wen,
    input  logic [31:0]               hub_rdata
);
    import qla_pkg::*;

    logic axis_off_ok;      // offset valid on an axis channel

    assign axis_off_ok = (req.addr.main.offset == OFF_ADC_DATA) ||
                         (req.addr.main.offset == OFF_DAC_CTRL);

    // ----------------------------------------------------------------------
    // strobe split and read mux, all combinational
    // ----------------------------------------------------------------------
    always_comb begin
        rsp       = '0;         // unmapped reads return zero
        axis_wen  = '0;
        board_wen = 1'b0;
        hub_wen   = 1'b0;

        if (req.addr.hub.space == ADDR_HUB) begin
            rsp.hit   = 1'b1;
            rsp.rdata = hub_rdata;
            hub_wen   = req.wen;
        end else if (req.addr.main.space == ADDR_MAIN) begin
            if (req.addr.main.chan == 4'd0) begin      // board registers
                if (req.addr.main.offset == OFF_BOARD_STATUS) begin
                    rsp.hit   = 1'b1;
                    rsp.rdata = board_rdata;
                    board_wen = req.wen;
                end
            end else if (axis_off_ok) begin
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (req.addr.main.chan == 4'(i + 1)) begin
                        rsp.hit   = 1'b1;
                        rsp.rdata = axis_rdata[i];
                        // feedback stays read only
                        axis_wen[i] = req.wen &
                                      (req.addr.main.offset == OFF_DAC_CTRL);
                    end
                end
            end
        end
    end

endmodule

// ==== src/qla_apb_bridge.sv ====
module qla_apb_bridge (
    input  logic              sysclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [15:0]       paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output qla_pkg::reg_req_t req,
    input  qla_pkg::reg_rsp_t rsp
);
    import qla_pkg::*;

    typedef enum logic {
        ACC_FIRST,      // first access cycle, strobe and sample
        ACC_DONE        // completion cycle, pready high
    } acc_state_t;

    acc_state_t state;
    logic       acc_first;

    // first cycle of an access phase
    assign acc_first = psel & penable & (state == ACC_FIRST);

    // apb holds addr and data for the whole transfer
    assign req.wen   = acc_first & pwrite;     // one-cycle pulse
    assign req.addr  = paddr;
    assign req.wdata = pwdata;

    assign pready = (state == ACC_DONE);

    // ----------------------------------------------------------------------
    // access sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state   <= ACC_FIRST;
            pslverr <= 1'b0;
        end else if (state == ACC_DONE) begin
            state   <= ACC_FIRST;      // transfer finished
            pslverr <= 1'b0;
        end else if (acc_first) begin
            state   <= ACC_DONE;
            pslverr <= ~rsp.hit;       // unmapped address
        end
    end

    // read word sampled with the strobe
    always_ff @(posedge sysclk) begin
        if (acc_first) begin
            prdata <= rsp.rdata;
        end
    end

endmodule

// ==== src/qla_axis_ctrl.sv ====
module qla_axis_ctrl (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic               wen,        // dac register write
    input  logic [31:0]        wdata,
    input  logic [3:0]         offset,
    output logic [31:0]        rdata,
    input  qla_pkg::axis_val_t fb,         // current feedback
    output qla_pkg::axis_val_t cmd,        // current command
    output logic               trip        // amplifier disable latch
);
    import qla_pkg::*;

    localparam int CW = $clog2(SAFETY_COUNT + 1);

    axis_val_t     fb_q;        // registered feedback
    logic [15:0]   fb_mag;
    logic [15:0]   cmd_mag;
    logic [17:0]   limit;       // 2 x cmd + margin
    logic          over;
    logic [CW-1:0] over_cnt;

    // distance from zero current
    function automatic logic [15:0] mag(axis_val_t v);
        logic [15:0] m;
        if (v[15]) begin
            m = v - AXIS_ZERO;
        end else begin
            m = AXIS_ZERO - v;
        end
        return m;
    endfunction

    // ----------------------------------------------------------------------
    // command and feedback registers
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cmd <= AXIS_ZERO;
        end else if (wen) begin
            cmd <= wdata[15:0];
        end
    end

    always_ff @(posedge sysclk) begin
        fb_q <= fb;
    end

    assign rdata = (offset == OFF_DAC_CTRL) ? {16'h0, cmd} : {16'h0, fb_q};

    // ----------------------------------------------------------------------
    // safety check, fb beyond twice the command
    // ----------------------------------------------------------------------
    assign fb_mag  = mag(fb_q);
    assign cmd_mag = mag(cmd);
    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over    = {2'b00, fb_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt <= '0;
            trip     <= 1'b0;
        end else if (wen) begin
            over_cnt <= '0;             // new command rearms the check
            trip     <= 1'b0;
        end else if (over) begin
            if (over_cnt != CW'(SAFETY_COUNT)) begin
                over_cnt <= over_cnt + 1'b1;    // saturates
            end
            if (over_cnt == CW'(SAFETY_COUNT - 1)) begin
                trip <= 1'b1;
            end
        end else begin
            over_cnt <= '0;             // run broken
        end
    end

endmodule

// ==== src/qla_board_regs.sv ====
module qla_board_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                wen,
    input  logic [31:0]         wdata,
    input  logic [3:0]          board_id,
    input  logic [NUM_AXES-1:0] trip,       // safety latches from the axes
    output logic [31:0]         rdata,
    output logic [NUM_AXES-1:0] amp_en,
    output logic                pwr_enable
);

    logic [NUM_AXES-1:0] amp_req;   // host enable request
    logic [15:0]         req_ext;
    logic [15:0]         trip_ext;

    // ----------------------------------------------------------------------
    // control bits
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_req    <= '0;
            pwr_enable <= 1'b0;
        end else if (wen) begin
            amp_req    <= wdata[NUM_AXES-1:0];
            pwr_enable <= wdata[19];
        end
    end

    // tripped axes are forced off
    assign amp_en = amp_req & ~trip;

    // ----------------------------------------------------------------------
    // status word
    // ----------------------------------------------------------------------
    assign req_ext  = 16'(amp_req);
    assign trip_ext = 16'(trip);

    always_comb begin
        rdata        = '0;
        rdata[3:0]   = req_ext[3:0];     // enable request
        rdata[11:8]  = trip_ext[3:0];    // safety trips
        rdata[19]    = pwr_enable;
        rdata[27:24] = board_id;
    end

endmodule

// ==== src/qla_hub_mem.sv ====
module qla_hub_mem (
    input  logic               sysclk,
    input  logic               wen,
    input  qla_pkg::reg_addr_t addr,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata
);

    logic [31:0] mem [16];     // 16 x 32 hub words

    // write at the end of the strobe cycle
    always_ff @(posedge sysclk) begin
        if (wen) begin
            mem[addr.hub.index] <= wdata;
        end
    end

    // async read, same cycle as the address
    assign rdata = mem[addr.hub.index];

endmodule

// ==== src/qla_pkg.sv ====
package qla_pkg;

    // ----------------------------------------------------------------------
    // register address, two views of the same 16-bit word
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [3:0] space;      // address space select
        logic [3:0] rsvd;
        logic [3:0] chan;       // 0 = board, 1..N = axis
        logic [3:0] offset;     // register within channel
    } main_addr_t;

    typedef struct packed {
        logic [3:0] space;
        logic [7:0] rsvd;
        logic [3:0] index;      // hub word
    } hub_addr_t;

    typedef union packed {
        main_addr_t main;
        hub_addr_t  hub;
    } reg_addr_t;

    // space codes, top nibble of the address
    localparam logic [3:0] ADDR_MAIN = 4'h0;
    localparam logic [3:0] ADDR_HUB  = 4'h1;

    // axis channel offsets
    localparam logic [3:0] OFF_ADC_DATA = 4'h0;     // feedback, read only
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;     // command, read/write

    // channel 0 offsets
    localparam logic [3:0] OFF_BOARD_STATUS = 4'h0;

    // ----------------------------------------------------------------------
    // current values and bus types
    // ----------------------------------------------------------------------
    typedef logic [15:0] axis_val_t;    // offset binary
    localparam axis_val_t AXIS_ZERO = 16'h8000;     // zero current

    typedef struct packed {
        logic      wen;         // single cycle write strobe
        reg_addr_t addr;
        logic [31:0] wdata;
    } reg_req_t;                // 49 bits

    typedef struct packed {
        logic [31:0] rdata;
        logic        hit;       // address is mapped
    } reg_rsp_t;                // 33 bits

    // safety check limits
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100;  // headroom on top of 2x cmd
    localparam int          SAFETY_COUNT  = 16;        // over-limit cycles to trip

endpackage

// ==== src/qla_top.sv ====
module qla_top #(
    parameter int NUM_AXES = 4
) (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    // apb slave
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [15:0]                          paddr,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    // board side
    input  logic [3:0]                           board_id,  // rotary switch
    input  qla_pkg::axis_val_t [NUM_AXES-1:0]    cur_fb,    // feedback words
    output qla_pkg::axis_val_t [NUM_AXES-1:0]    cur_cmd,   // command words
    output logic [NUM_AXES-1:0]                  amp_en,
    output logic                                 pwr_enable
);
    import qla_pkg::*;

    reg_req_t                   req;
    reg_rsp_t                   rsp;
    logic [NUM_AXES-1:0]        axis_wen;
    logic [NUM_AXES-1:0][31:0]  axis_rdata;
    logic [NUM_AXES-1:0]        trip;       // per-axis safety latch
    logic                       board_wen;
    logic [31:0]                board_rdata;
    logic                       hub_wen;
    logic [31:0]                hub_rdata;

    // ----------------------------------------------------------------------
    // host access path
    // ----------------------------------------------------------------------
    qla_apb_bridge apb_bridge (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .req    (req),
        .rsp    (rsp)
    );

    qla_addr_decode #(.NUM_AXES(NUM_AXES)) addr_decode (
        .req        (req),
        .rsp        (rsp),
        .axis_wen   (axis_wen),
        .axis_rdata (axis_rdata),
        .board_wen  (board_wen),
        .board_rdata(board_rdata),
        .hub_wen    (hub_wen),
        .hub_rdata  (hub_rdata)
    );

    // ----------------------------------------------------------------------
    // register targets
    // ----------------------------------------------------------------------
    qla_hub_mem hub (
        .sysclk(sysclk),
        .wen   (hub_wen),
        .addr  (req.addr),
        .wdata (req.wdata),
        .rdata (hub_rdata)
    );

    qla_board_regs #(.NUM_AXES(NUM_AXES)) chan0 (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .wen       (board_wen),
        .wdata     (req.wdata),
        .board_id  (board_id),
        .trip      (trip),
        .rdata     (board_rdata),
        .amp_en    (amp_en),
        .pwr_enable(pwr_enable)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis   // axis i+1 on the bus
        qla_axis_ctrl axis (
            .sysclk(sysclk),
            .rst_n (rst_n),
            .wen   (axis_wen[i]),
            .wdata (req.wdata),
            .offset(req.addr.main.offset),
            .rdata (axis_rdata[i]),
            .fb    (cur_fb[i]),
            .cmd   (cur_cmd[i]),
            .trip  (trip[i])
        );
    end

endmodule
